/* src.f */
design/dcache_pkg.sv
design/dcache_req_buffer.sv
design/dcache_bypass_ctrl.sv
design/dcache_lane_align.sv
design/dummy_dcache.sv
testbench/dcache_bypass_chk.sv
testbench/tb_bus_model.sv
testbench/tb_dummy_dcache.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_dummy_dcache -o sim_dcache
./obj_dir/sim_dcache | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* testbench/tb_dummy_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dummy_dcache;

    import dcache_pkg::*;

    typedef struct packed {
        logic [31:0]  rdata;
        logic [127:0] wr_data;
        logic [15:0]  wr_strb;
        xfer_type_e   rd_type;
        xfer_type_e   wr_type;
    } exp_t;

    localparam logic [31:0] mem_key = 32'hc3a5_0f1e;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic valid = 1'b0;
    logic op = 1'b0;
    logic uncache = 1'b0;
    logic flush_i = 1'b0;
    logic [31:0] pc = '0;
    logic [31:0] addr = '0;
    logic [31:0] wdata = '0;
    logic [31:0] flush_pc = '0;
    logic [3:0] wstrb = '0;
    logic [2:0] rd_type_i = '0;
    logic [2:0] wr_type_i = '0;
    logic stall_en = 1'b0;

    logic cache_ready, cache_ack, addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last;
    logic wr_req, wr_rdy;
    logic [31:0] rdata, rd_addr, wr_addr;
    logic [2:0] rd_type, wr_type;
    logic [127:0] ret_data, wr_data;
    logic [15:0] wr_wstrb;
    int wr_log;

    cpu_req_t cur_req;
    exp_t cur_exp;
    int acks = 0;
    int oks = 0;
    int rd_x = 0;
    int wr_x = 0;
    int stalled_flushes = 0;
    int mon_errs = 0;
    int main_errs = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    dummy_dcache DUT (
        .clk(clk), .rst(rst), .valid(valid), .op(op), .uncache(uncache), .pc(pc),
        .index(addr[11:4]), .tag(addr[31:12]), .offset(addr[3:0]), .wstrb(wstrb),
        .wdata(wdata), .rd_type_i(rd_type_i), .wr_type_i(wr_type_i), .flush_pc(flush_pc),
        .flush_i(flush_i), .cache_ready(cache_ready), .cache_ack(cache_ack),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata), .rd_req(rd_req),
        .rd_type(rd_type), .rd_addr(rd_addr), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .ret_data(ret_data), .wr_req(wr_req), .wr_type(wr_type),
        .wr_addr(wr_addr), .wr_wstrb(wr_wstrb), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    tb_bus_model u_bus (
        .clk(clk), .rst(rst), .stall_en(stall_en), .rd_req(rd_req), .rd_addr(rd_addr),
        .rd_rdy(rd_rdy), .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_rdy(wr_rdy), .wr_count(wr_log)
    );

    bind dcache_bypass_ctrl dcache_bypass_chk u_chk (
        .clk(clk), .rst(rst), .state(state), .rd_req(rd_req), .rd_rdy(rd_rdy),
        .rd_addr(rd_addr), .wr_req(wr_req), .data_ok(data_ok)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // expected bus and cpu view of one request
    function automatic exp_t ref_model(input cpu_req_t r);
        exp_t e;
        int lane;
        e = '0;
        lane = int'(r.addr.raw[3:2]);
        e.rdata = {r.addr.raw[31:4], r.addr.raw[3:2], 2'b00} ^ mem_key;
        e.wr_data[lane*32 +: 32] = r.wdata;
        e.wr_strb[lane*4 +: 4] = r.wstrb;
        e.rd_type = r.uncache ? r.rd_type : xfer_line;
        e.wr_type = r.wr_type;
        return e;
    endfunction

    function automatic cpu_req_t make_req(input logic st, input logic unc, input logic [31:0] p,
                                          input logic [31:0] a, input xfer_type_e t);
        cpu_req_t r;
        r.op = st;
        r.uncache = unc;
        r.pc = p;
        r.addr.raw = a;
        r.wstrb = 4'($urandom % 15 + 1);
        r.wdata = $urandom;
        r.rd_type = t;
        r.wr_type = t;
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            mon_errs++;
        end
    endtask

    task automatic check_line(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            mon_errs++;
        end
    endtask

    task automatic check_strb(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            mon_errs++;
        end
    endtask

    task automatic check_type(input string name, input xfer_type_e got, input xfer_type_e exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            mon_errs++;
        end
    endtask

    // compares every bus transfer and completion against the reference
    always @(posedge clk) begin
        if (!rst) begin
            if (cache_ack) acks++;
            if (wr_req && !wr_rdy && flush_i) stalled_flushes++;  // flush on a held write
            if (addr_ok !== data_ok) begin
                $display("ERR addr_ok %h data_ok %h", addr_ok, data_ok);
                mon_errs++;
            end
            if (rd_req && rd_rdy) begin
                rd_x++;
                check_word("rd_addr", rd_addr, cur_req.addr.raw);
                check_type("rd_type", xfer_type_e'(rd_type), cur_exp.rd_type);
            end
            if (wr_req && wr_rdy) begin
                wr_x++;
                check_word("wr_addr", wr_addr, cur_req.addr.raw);
                check_line("wr_data", wr_data, cur_exp.wr_data);
                check_strb("wr_wstrb", wr_wstrb, cur_exp.wr_strb);
                check_type("wr_type", xfer_type_e'(wr_type), cur_exp.wr_type);
            end
            if (data_ok) begin
                oks++;
                if (!cur_req.op) check_word("rdata", rdata, cur_exp.rdata);
            end
        end
    end

    task automatic expect_val(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            main_errs++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!cache_ready && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!cache_ready) begin
            $display("timeout waiting for cache_ready");
            main_errs++;
        end
    endtask

    task automatic drive_req(input cpu_req_t r);
        wait_ready();
        cur_req = r;
        cur_exp = ref_model(r);
        op = r.op;
        uncache = r.uncache;
        pc = r.pc;
        addr = r.addr.raw;
        wstrb = r.wstrb;
        wdata = r.wdata;
        rd_type_i = r.rd_type;
        wr_type_i = r.wr_type;
        valid = 1'b1;  // idle, so taken at the next edge
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic wait_ok(input int start);
        int n;
        n = 0;
        while (oks == start && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (oks == start) begin
            $display("timeout waiting for data_ok");
            main_errs++;
        end
    endtask

    // one access start to end, plus counts of acks, transfers and completions
    task automatic run_access(input cpu_req_t r, input logic flush_hit, input logic flush_miss);
        int a0, o0, r0, w0, l0;
        a0 = acks;
        o0 = oks;
        r0 = rd_x;
        w0 = wr_x;
        l0 = wr_log;
        drive_req(r);
        if (flush_hit || flush_miss) begin
            flush_pc = flush_hit ? r.pc - 32'(($urandom % 2) * 4) : r.pc + 4;
            flush_i = 1'b1;  // look_up cycle
            @(negedge clk);
            flush_i = 1'b0;
        end
        if (!flush_hit) begin
            valid = 1'b1;  // cpu keeps asking while busy, no ack allowed
            wait_ok(o0);
            valid = 1'b0;
        end
        wait_ready();
        repeat (4) @(negedge clk);
        expect_val("acks", acks - a0, 1);
        expect_val("data_ok count", oks - o0, flush_hit ? 0 : 1);
        expect_val("read transfers", rd_x - r0, (r.op || flush_hit) ? 0 : 1);
        expect_val("write transfers", wr_x - w0, r.op ? 1 : 0);
        expect_val("write log", wr_log - l0, r.op ? 1 : 0);
    endtask

    // flush held high for as long as the write sits on the bus
    task automatic store_with_flush(input cpu_req_t r);
        int o0, w0, n;
        o0 = oks;
        w0 = wr_x;
        drive_req(r);
        n = 0;
        while (!wr_req && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!wr_req) begin
            $display("store never reached the write bus");
            main_errs++;
        end
        flush_pc = r.pc;
        flush_i = 1'b1;
        wait_ok(o0);
        flush_i = 1'b0;
        wait_ready();
        repeat (4) @(negedge clk);
        expect_val("data_ok count", oks - o0, 1);
        expect_val("write transfers", wr_x - w0, 1);
    endtask

    task automatic finish_test(input string name, input int start);
        if (mon_errs + main_errs == start) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: failed with %0d errors", name, mon_errs + main_errs - start);
            tests_bad++;
        end
    endtask

    initial begin
        int e0;
        cpu_req_t r;
        void'($urandom(32'h3ffd9ca6));
        repeat (3) @(negedge clk);
        rst = 1'b0;
        e0 = 0;
        expect_val("cache_ack", 32'(cache_ack), 0);
        expect_val("addr_ok", 32'(addr_ok), 0);
        expect_val("data_ok", 32'(data_ok), 0);
        expect_val("rd_req", 32'(rd_req), 0);
        expect_val("wr_req", 32'(wr_req), 0);
        expect_val("cache_ready", 32'(cache_ready), 1);
        finish_test("reset", e0);

        e0 = mon_errs + main_errs;
        for (int i = 0; i < 4; i++) begin
            run_access(make_req(0, 0, $urandom, {$urandom} & ~32'hc | 32'(i << 2),
                                xfer_word), 0, 0);
        end
        run_access(make_req(0, 1, $urandom, $urandom, xfer_byte), 0, 0);
        run_access(make_req(0, 1, $urandom, $urandom, xfer_half), 0, 0);
        run_access(make_req(0, 1, $urandom, $urandom, xfer_word), 0, 0);
        finish_test("reads", e0);

        e0 = mon_errs + main_errs;
        for (int i = 0; i < 4; i++) begin
            run_access(make_req(1, i[0], $urandom, {$urandom} & ~32'hc | 32'(i << 2),
                                xfer_word), 0, 0);
        end
        finish_test("stores", e0);

        e0 = mon_errs + main_errs;
        stall_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            r = make_req(1'($urandom % 2), 1'($urandom % 2), $urandom, $urandom, xfer_word);
            run_access(r, 0, 0);
        end
        stall_en = 1'b0;
        finish_test("back-pressure", e0);

        e0 = mon_errs + main_errs;
        run_access(make_req(0, 1, 32'h0000_8000 + ($urandom & 32'hff0), $urandom, xfer_word),
                   1, 0);
        run_access(make_req(0, 0, 32'h0000_8000, $urandom, xfer_word), 0, 1);
        r = make_req(1, 1, 32'h0000_9000, $urandom, xfer_half);
        stall_en = 1'b1;  // the write has to wait on wr_rdy under the flush
        for (int i = 0; i < 16 && stalled_flushes == 0; i++) begin
            store_with_flush(r);
        end
        stall_en = 1'b0;
        if (stalled_flushes == 0) begin
            $display("flush never met a stalled write");
            main_errs++;
        end
        finish_test("flush", e0);

        $display("tests passed %0d failed %0d errors %0d", tests_ok, tests_bad,
                 mon_errs + main_errs);
        if (tests_bad == 0 && mon_errs + main_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_bus_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_model (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall_en,  // random ready when set
    input  logic         rd_req,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [127:0] ret_data,
    input  logic         wr_req,
    output logic         wr_rdy,
    output int           wr_count
);

    localparam logic [31:0] fill_key = 32'hc3a5_0f1e;

    logic         rd_rdy_q = 1'b0;
    logic         wr_rdy_q = 1'b0;
    logic         ret_valid_q = 1'b0;
    logic [127:0] ret_data_q = '0;
    logic         pend = 1'b0;
    logic [31:0]  pend_addr = '0;
    int           delay = 0;
    int           wr_count_q = 0;

    // every word of memory is its own address mixed with a key
    function automatic logic [127:0] beat_of(input logic [31:0] a);
        logic [127:0] beat;
        for (int k = 0; k < 4; k++) begin
            beat[k*32 +: 32] = {a[31:4], 2'(k), 2'b00} ^ fill_key;
        end
        return beat;
    endfunction

    // the handshake seen here is the one taken at the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            rd_rdy_q = 1'b0;
            wr_rdy_q = 1'b0;
            ret_valid_q = 1'b0;
            pend = 1'b0;
        end else begin
            ret_valid_q = 1'b0;
            if (pend) begin
                if (delay == 0) begin
                    ret_valid_q = 1'b1;
                    ret_data_q = beat_of(pend_addr);
                    pend = 1'b0;
                end else begin
                    delay--;
                end
            end
            rd_rdy_q = stall_en ? 1'($urandom % 2) : 1'b1;
            wr_rdy_q = stall_en ? 1'($urandom % 2) : 1'b1;
            if (rd_req && rd_rdy_q) begin
                pend = 1'b1;
                pend_addr = rd_addr;
                delay = $urandom % 3;
            end
            if (wr_req && wr_rdy_q) wr_count_q++;  // write log
        end
    end

    assign rd_rdy    = rd_rdy_q;
    assign wr_rdy    = wr_rdy_q;
    assign ret_valid = ret_valid_q;
    assign ret_last  = ret_valid_q;  // single beat returns
    assign ret_data  = ret_data_q;
    assign wr_count  = wr_count_q;

endmodule

`default_nettype wire

/* testbench/dcache_bypass_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_bypass_chk (
    input logic                      clk,
    input logic                      rst,
    input dcache_pkg::bypass_state_e state,
    input logic                      rd_req,
    input logic                      rd_rdy,
    input logic [31:0]               rd_addr,
    input logic                      wr_req,
    input logic                      data_ok
);

    import dcache_pkg::*;

    a_one_bus_req : assert property (@(posedge clk) disable iff (rst)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req raised together");

    // completion only comes out of the two bus states
    a_ok_state : assert property (@(posedge clk) disable iff (rst)
        data_ok |-> (state == read_wait || state == write_req))
        else $error("data_ok outside read_wait and write_req");

    a_rd_hold : assert property (@(posedge clk) disable iff (rst)
        (rd_req && !rd_rdy) |=> $stable(rd_addr))
        else $error("rd_addr moved while the read was stalled");

endmodule

`default_nettype wire

/* design/dummy_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dummy_dcache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic                          op,  // 1 store, 0 load
    input  logic                          uncache,
    input  logic [31:0]                   pc,
    input  logic [7:0]                    index,  // addr[11:4]
    input  logic [19:0]                   tag,
    input  logic [3:0]                    offset,  // addr[3:0]
    input  logic [3:0]                    wstrb,
    input  logic [31:0]                   wdata,
    input  logic [2:0]                    rd_type_i,
    input  logic [2:0]                    wr_type_i,
    input  logic [31:0]                   flush_pc,
    input  logic                          flush_i,
    output logic                          cache_ready,
    output logic                          cache_ack,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [31:0]                   rdata,
    output logic                          rd_req,
    output logic [2:0]                    rd_type,
    output logic [31:0]                   rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic                          ret_last,  // single beat only, not looked at
    input  logic [dcache_pkg::line_w-1:0] ret_data,
    output logic                          wr_req,
    output logic [2:0]                    wr_type,
    output logic [31:0]                   wr_addr,
    output logic [dcache_pkg::strb_w-1:0] wr_wstrb,
    output logic [dcache_pkg::line_w-1:0] wr_data,
    input  logic                          wr_rdy
);

    import dcache_pkg::*;

    cpu_req_t          cpu_req;
    held_req_t         held;
    logic              accept;
    logic              in_write;
    logic              done;
    logic [data_w-1:0] lane_word;
    xfer_type_e        rd_type_e;
    xfer_type_e        wr_type_e;

    // flat cpu inputs into one request word
    assign cpu_req.op       = op;
    assign cpu_req.uncache  = uncache;
    assign cpu_req.pc       = pc;
    assign cpu_req.addr.raw = {tag, index, offset};
    assign cpu_req.wstrb    = wstrb;
    assign cpu_req.wdata    = wdata;
    assign cpu_req.rd_type  = xfer_type_e'(rd_type_i);
    assign cpu_req.wr_type  = xfer_type_e'(wr_type_i);

    dcache_req_buffer u_req_buffer (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .req      (cpu_req),
        .accept   (accept),
        .flush_i  (flush_i),
        .flush_pc (flush_pc),
        .in_write (in_write),
        .done     (done),
        .held     (held)
    );

    dcache_bypass_ctrl u_bypass_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .held        (held),
        .accept      (accept),
        .cache_ready (cache_ready),
        .in_write    (in_write),
        .done        (done),
        .rd_req      (rd_req),
        .rd_type     (rd_type_e),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .wr_req      (wr_req),
        .wr_type     (wr_type_e),
        .wr_addr     (wr_addr),
        .wr_rdy      (wr_rdy),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok)
    );

    dcache_lane_align u_lane_align (
        .held     (held),
        .ret_data (ret_data),
        .wr_data  (wr_data),
        .wr_wstrb (wr_wstrb),
        .rdata    (lane_word)
    );

    assign cache_ack = accept;  // ack only while idle
    assign rd_type   = rd_type_e;
    assign wr_type   = wr_type_e;
    assign rdata     = data_ok ? lane_word : '0;  // zero outside data_ok

endmodule

`default_nettype wire

/* design/dcache_lane_align.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_lane_align (
    input  dcache_pkg::held_req_t         held,
    input  logic [dcache_pkg::line_w-1:0] ret_data,
    output logic [dcache_pkg::line_w-1:0] wr_data,
    output logic [dcache_pkg::strb_w-1:0] wr_wstrb,
    output logic [dcache_pkg::data_w-1:0] rdata
);

    import dcache_pkg::*;

    logic [1:0] lane_sel;

    assign lane_sel = held.req.addr.fields.word;  // addr[3:2]

    // store data goes to one 32-bit lane, the rest stays zero
    always_comb begin
        wr_data  = '0;
        wr_wstrb = '0;
        for (int i = 0; i < lanes; i++) begin
            if (int'(lane_sel) == i) begin
                wr_data[i*data_w +: data_w]           = held.req.wdata;
                wr_wstrb[i*lane_strb_w +: lane_strb_w] = held.req.wstrb;
            end
        end
    end

    // load word picked from the returned beat
    always_comb begin
        rdata = '0;
        for (int i = 0; i < lanes; i++) begin
            if (int'(lane_sel) == i) begin
                rdata = ret_data[i*data_w +: data_w];
            end
        end
    end

endmodule

`default_nettype wire

/* design/dcache_bypass_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_bypass_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  dcache_pkg::held_req_t         held,
    output logic                          accept,
    output logic                          cache_ready,
    output logic                          in_write,
    output logic                          done,
    output logic                          rd_req,
    output dcache_pkg::xfer_type_e        rd_type,
    output logic [dcache_pkg::addr_w-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    output logic                          wr_req,
    output dcache_pkg::xfer_type_e        wr_type,
    output logic [dcache_pkg::addr_w-1:0] wr_addr,
    input  logic                          wr_rdy,
    output logic                          addr_ok,
    output logic                          data_ok
);

    import dcache_pkg::*;

    bypass_state_e state;
    bypass_state_e next_state;
    logic          rd_done;
    logic          wr_done;
    logic          dropped;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (accept) next_state = look_up;
            end
            look_up: begin
                if (!held.valid) next_state = idle;  // flushed during lookup
                else if (held.req.op) next_state = write_req;
                else next_state = read_req;
            end
            read_req: begin
                if (!held.valid) next_state = idle;
                else if (rd_rdy) next_state = read_wait;
            end
            read_wait: begin
                // the bridge owes us a beat even after a flush, so drain it
                if (ret_valid) next_state = idle;
            end
            write_req: begin
                if (!held.valid || wr_rdy) next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

    // cpu side handshake
    assign accept      = (state == idle) && valid;
    assign cache_ready = (state == idle) && !held.valid;
    assign in_write    = state == write_req;

    assign rd_done = (state == read_wait) && ret_valid && held.valid;
    assign wr_done = (state == write_req) && wr_rdy && held.valid;
    assign dropped = (state != idle) && !held.valid;

    assign done    = rd_done || wr_done || dropped;
    assign addr_ok = rd_done || wr_done;
    assign data_ok = rd_done || wr_done;

    // bus side requests, held steady until the bridge takes them
    assign rd_req  = (state == read_req) && held.valid;
    assign rd_addr = held.req.addr.raw;  // not aligned
    assign rd_type = held.req.uncache ? held.req.rd_type : xfer_line;

    assign wr_req  = (state == write_req) && held.valid;
    assign wr_addr = held.req.addr.raw;
    assign wr_type = held.req.wr_type;

endmodule

`default_nettype wire

/* design/dcache_req_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_req_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid,
    input  dcache_pkg::cpu_req_t      req,
    input  logic                      accept,
    input  logic                      flush_i,
    input  logic [dcache_pkg::addr_w-1:0] flush_pc,
    input  logic                      in_write,
    input  logic                      done,
    output dcache_pkg::held_req_t     held
);

    import dcache_pkg::*;

    logic     valid_q;
    cpu_req_t req_q;
    logic     pc_hit;
    logic     kill;

    // a flush only reaches instructions at or after flush_pc
    assign pc_hit = flush_pc <= req_q.pc;

    // a store already on the bus is past the point of no return
    assign kill = flush_i && valid_q && pc_hit && !in_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (kill) begin
            valid_q <= 1'b0;  // cancelled by pipeline flush
        end else if (accept) begin
            valid_q <= valid;
        end else if (done) begin
            valid_q <= 1'b0;  // request retired
        end
    end

    // payload only moves on a new request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    assign held.valid = valid_q;
    assign held.req   = req_q;

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int addr_w = 32;  // cpu and bus address
    localparam int data_w = 32;  // cpu load/store word
    localparam int line_w = 128;  // one bus beat
    localparam int strb_w = 16;  // byte strobes per beat

    localparam int lanes = line_w / data_w;  // cpu words per beat
    localparam int lane_strb_w = strb_w / lanes;

    // transfer size codes as the bus bridge expects them
    typedef enum logic [2:0] {
        xfer_byte = 3'b000,
        xfer_half = 3'b001,
        xfer_word = 3'b010,
        xfer_line = 3'b100
    } xfer_type_e;

    typedef struct packed {
        logic [19:0] tag;  // pfn from the tlb
        logic [7:0] index;
        logic [1:0] word;  // lane within the 128-bit beat
        logic [1:0] byte_off;
    } addr_fields_t;

    // the bus sees raw, the lane logic looks at fields
    typedef union packed {
        logic [addr_w-1:0] raw;
        addr_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic op;  // 1 for store
        logic uncache;
        logic [addr_w-1:0] pc;
        cache_addr_u addr;
        logic [data_w/8-1:0] wstrb;
        logic [data_w-1:0] wdata;
        xfer_type_e rd_type;
        xfer_type_e wr_type;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        cpu_req_t req;
    } held_req_t;

    typedef enum logic [2:0] {
        idle,
        look_up,
        read_req,
        read_wait,
        write_req
    } bypass_state_e;

endpackage

`default_nettype wire
